//--- hdl/ualink_defines.svh
//******************************
// build-time sizes for the ingress stage
// included by the package, the RTL and the testbench
//******************************

`ifndef UALINK_DEFINES_SVH
`define UALINK_DEFINES_SVH

// payload beat width in bits
`define UL_DATA_WIDTH 64

// sideband carried next to every beat
`define UL_TUSER_WIDTH 32

// ingress ports, one queue each
`define UL_NUM_QUEUES 5

// log2 of entries per queue
// kept small so that back-pressure shows up quickly
`define UL_FIFO_DEPTH_BITS 4

`endif

//--- hdl/ualink_pkg.sv
//******************************
// beat and index types shared by the queues and the arbiter
// import with ualink_pkg::*
//******************************
`include "ualink_defines.svh"

package ualink_pkg;

   // one stream beat, split by field
   typedef logic [`UL_DATA_WIDTH-1:0]   tdata_t;
   typedef logic [`UL_DATA_WIDTH/8-1:0] tstrb_t;   // one bit per byte lane
   typedef logic [`UL_TUSER_WIDTH-1:0]  tuser_t;

   // selects one ingress queue
   typedef logic [$clog2(`UL_NUM_QUEUES)-1:0] queue_idx_t;

   // word held in each queue entry
   // tlast sits on top, same packing as the stream fields
   typedef struct packed {
      logic   tlast;
      tuser_t tuser;
      tstrb_t tstrb;
      tdata_t tdata;
   } beat_t;

endpackage

//--- hdl/stream_fifo.sv
//******************************
// fall-through queue for one ingress port
// head entry shows combinationally on dout while empty is low
// nearly_full drops the source ready with one slot still free
//******************************
`include "ualink_defines.svh"

module stream_fifo
   import ualink_pkg::*;
(
   input  logic  axi_aclk,
   input  logic  axi_resetn,

   input  logic  wr_en,        // push din this edge
   input  beat_t din,

   input  logic  rd_en,        // pop the head this edge
   output beat_t dout,         // current head

   output logic  empty,
   output logic  nearly_full   // at most one free slot
);

   localparam int DEPTH_BITS = `UL_FIFO_DEPTH_BITS;
   localparam int DEPTH      = 1 << DEPTH_BITS;

   // occupancy thresholds, one bit wider than the pointers
   localparam logic [DEPTH_BITS:0] CNT_FULL   = (DEPTH_BITS + 1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] CNT_NEARLY = (DEPTH_BITS + 1)'(DEPTH - 1);

   beat_t mem [DEPTH];

   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;    // entries held
   logic                  full;

   // storage array
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   // pointers and occupancy
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
         end

         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push and pop together
         endcase
      end
   end

   assign dout        = mem[rd_ptr];   // fall-through head
   assign empty       = (count == '0);
   assign full        = (count == CNT_FULL);
   assign nearly_full = (count >= CNT_NEARLY);

   // the port wiring above must throttle on nearly_full
   // so a push never lands on a full queue
   a_no_overflow: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      !(wr_en && full)
   ) else $error("push into full queue");

   // arbiter pops only a queue that shows a head
   a_no_underflow: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      !(rd_en && empty)
   ) else $error("pop from empty queue");

endmodule

//--- hdl/queue_arbiter.sv
//******************************
// round-robin packet arbiter for the ingress queues
// hunts for a non-empty queue then streams it up to tlast
// the selected head drives the master port with no added latency
//******************************
`include "ualink_defines.svh"

module queue_arbiter
   import ualink_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // queue side
   input  beat_t                     head [`UL_NUM_QUEUES],   // head beat of every queue
   input  logic [`UL_NUM_QUEUES-1:0] empty,
   output logic [`UL_NUM_QUEUES-1:0] rd_en,                   // one-hot pop

   // master stream
   output tdata_t                    m_axis_tdata,
   output tstrb_t                    m_axis_tstrb,
   output tuser_t                    m_axis_tuser,
   output logic                      m_axis_tlast,
   output logic                      m_axis_tvalid,
   input  logic                      m_axis_tready
);

   typedef enum logic {
      HUNT,     // looking for a queue with data
      STREAM    // inside a packet, hold the queue
   } arb_state_t;

   localparam queue_idx_t LAST_QUEUE = queue_idx_t'(`UL_NUM_QUEUES - 1);

   arb_state_t state;
   arb_state_t state_next;

   queue_idx_t cur_queue;
   queue_idx_t cur_queue_next;
   queue_idx_t cur_queue_plus1;

   beat_t sel_beat;
   logic  beat_acc;     // beat leaves this edge

   // rotation order 0,1,..,N-1,0
   assign cur_queue_plus1 = (cur_queue == LAST_QUEUE) ? '0 : cur_queue + 1'b1;

   // output mux
   assign sel_beat      = head[cur_queue];
   assign m_axis_tdata  = sel_beat.tdata;
   assign m_axis_tstrb  = sel_beat.tstrb;
   assign m_axis_tuser  = sel_beat.tuser;
   assign m_axis_tlast  = sel_beat.tlast;
   assign m_axis_tvalid = ~empty[cur_queue];

   assign beat_acc = m_axis_tvalid & m_axis_tready;

   always_comb begin
      state_next     = state;
      cur_queue_next = cur_queue;
      rd_en          = '0;

      case (state)
         HUNT: begin
            if (empty[cur_queue]) begin
               cur_queue_next = cur_queue_plus1;   // nothing here, move on
            end else if (m_axis_tready) begin
               rd_en[cur_queue] = 1'b1;
               if (sel_beat.tlast) begin
                  cur_queue_next = cur_queue_plus1;   // single-beat packet done
               end else begin
                  state_next = STREAM;
               end
            end
         end

         STREAM: begin
            // queue may run dry mid packet, then just wait
            if (beat_acc) begin
               rd_en[cur_queue] = 1'b1;
               if (sel_beat.tlast) begin
                  state_next     = HUNT;
                  cur_queue_next = cur_queue_plus1;
               end
            end
         end

         default: begin
            state_next = HUNT;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= HUNT;
         cur_queue <= '0;
      end else begin
         state     <= state_next;
         cur_queue <= cur_queue_next;
      end
   end

   // pointer stays on a queue that exists
   a_ptr_range: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      cur_queue <= LAST_QUEUE
   ) else $error("queue pointer out of range");

   // no other queue may cut in before tlast has left
   a_ptr_hold: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      (state == STREAM) && !(beat_acc && sel_beat.tlast) |=> $stable(cur_queue)
   ) else $error("queue pointer moved inside a packet");

endmodule

//--- hdl/ualink_ingress_top.sv
//******************************
// five-port packet ingress stage
// each slave stream fills its own queue, the arbiter drains
// whole packets round-robin onto the single master stream
//******************************
`include "ualink_defines.svh"

module ualink_ingress_top
   import ualink_pkg::*;
(
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // slave streams, element q belongs to ingress port q
   input  tdata_t                    s_axis_tdata [`UL_NUM_QUEUES],
   input  tstrb_t                    s_axis_tstrb [`UL_NUM_QUEUES],
   input  tuser_t                    s_axis_tuser [`UL_NUM_QUEUES],
   input  logic [`UL_NUM_QUEUES-1:0] s_axis_tvalid,
   input  logic [`UL_NUM_QUEUES-1:0] s_axis_tlast,
   output logic [`UL_NUM_QUEUES-1:0] s_axis_tready,

   // master stream toward the switch core
   output tdata_t                    m_axis_tdata,
   output tstrb_t                    m_axis_tstrb,
   output tuser_t                    m_axis_tuser,
   output logic                      m_axis_tlast,
   output logic                      m_axis_tvalid,
   input  logic                      m_axis_tready
);

   // per-queue status and head beats
   beat_t                     head [`UL_NUM_QUEUES];
   logic [`UL_NUM_QUEUES-1:0] empty;
   logic [`UL_NUM_QUEUES-1:0] nearly_full;
   logic [`UL_NUM_QUEUES-1:0] rd_en;          // from the arbiter, one-hot
   logic [`UL_NUM_QUEUES-1:0] wr_en;          // accepted ingress beats

   for (genvar q = 0; q < `UL_NUM_QUEUES; q++) begin : g_port
      beat_t in_beat;

      // ready backs off one slot early
      assign s_axis_tready[q] = ~nearly_full[q];
      assign wr_en[q]         = s_axis_tvalid[q] & s_axis_tready[q];

      // pack the loose stream fields into one queue word
      assign in_beat.tlast = s_axis_tlast[q];
      assign in_beat.tuser = s_axis_tuser[q];
      assign in_beat.tstrb = s_axis_tstrb[q];
      assign in_beat.tdata = s_axis_tdata[q];

      stream_fifo ingress_q (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .wr_en       (wr_en[q]),
         .din         (in_beat),
         .rd_en       (rd_en[q]),
         .dout        (head[q]),
         .empty       (empty[q]),
         .nearly_full (nearly_full[q])
      );
   end

   // packet arbiter and output mux
   queue_arbiter arb (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .head          (head),
      .empty         (empty),
      .rd_en         (rd_en),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

endmodule

//--- tb/tb_ualink_ingress.sv
//******************************
// testbench for the five-port ingress stage
// LFSR packets on every port, checked against per-port expected queues
// plus directed round-robin order and back-pressure runs
//******************************
`include "ualink_defines.svh"

module tb_ualink_ingress
   import ualink_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NQ          = `UL_NUM_QUEUES;
   localparam int CLK_HALF    = 20;
   localparam int MAX_PKT_LEN = 12;
   localparam int RAND_PKTS   = 8;                                // per port, random run
   localparam int FIFO_FILL   = (1 << `UL_FIFO_DEPTH_BITS) - 1;   // one slot kept free
   localparam int BP_PORT     = 2;

   // round-robin run, back-pressure run, random run
   localparam int BEAT_BUDGET     = NQ * MAX_PKT_LEN + FIFO_FILL + MAX_PKT_LEN
                                    + NQ * RAND_PKTS * MAX_PKT_LEN;
   localparam int WATCHDOG_CYCLES = BEAT_BUDGET * 40 + 1000;

   logic                      axi_aclk;
   logic                      axi_resetn;

   tdata_t                    s_axis_tdata [NQ];
   tstrb_t                    s_axis_tstrb [NQ];
   tuser_t                    s_axis_tuser [NQ];
   logic [`UL_NUM_QUEUES-1:0] s_axis_tvalid;
   logic [`UL_NUM_QUEUES-1:0] s_axis_tlast;
   logic [`UL_NUM_QUEUES-1:0] s_axis_tready;

   tdata_t                    m_axis_tdata;
   tstrb_t                    m_axis_tstrb;
   tuser_t                    m_axis_tuser;
   logic                      m_axis_tlast;
   logic                      m_axis_tvalid;
   logic                      m_axis_tready;

   // stimulus control, written by the sequence only
   int   pkt_quota [NQ] = '{default: 0};   // packets each source may start
   bit   gap_en     = 1'b0;
   bit   sink_rand  = 1'b0;
   logic sink_level = 1'b0;

   // source state, owned by the driver
   int          seq_num    [NQ] = '{default: 0};   // packets started so far
   int          beats_left [NQ] = '{default: 0};
   logic [15:0] lfsr_state      = 16'd85;

   // reference model, owned by the monitor
   beat_t      exp_q [NQ][$];
   int         acc_cnt [NQ] = '{default: 0};   // accepted ingress beats
   queue_idx_t out_order [$];                  // port of each output packet
   bit         in_pkt   = 1'b0;
   tuser_t     pkt_user = '0;
   int         out_cnt  = 0;

   ualink_ingress_top DUT (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tstrb  (s_axis_tstrb),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tstrb  (m_axis_tstrb),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #CLK_HALF axi_aclk = ~axi_aclk;
   end

   // 16-bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end else begin
         return s >> 1;
      end
   endfunction

   // one step per bit taken
   function automatic logic [63:0] draw_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(input string name, input tdata_t got, input tdata_t want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   task automatic check_strb(input string name, input tstrb_t got, input tstrb_t want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   task automatic check_user(input string name, input tuser_t got, input tuser_t want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   task automatic check_last(input string name, input logic got, input logic want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   // handshake flags
   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   task automatic check_port(input string name, input queue_idx_t got, input queue_idx_t want);
      if (got !== want) begin
         stop_with_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, want));
      end
   endtask

   // source q, holds its beat while stalled
   task automatic drive_port(input int q);
      logic stalled;
      stalled = s_axis_tvalid[q] && !s_axis_tready[q];
      if (!stalled) begin
         if (beats_left[q] == 0 && seq_num[q] < pkt_quota[q]) begin
            beats_left[q] = int'(draw_bits(4)) % MAX_PKT_LEN + 1;   // 1 to 12 beats
            seq_num[q]    = seq_num[q] + 1;
         end
         if (beats_left[q] > 0 && !(gap_en && draw_bits(2) == '0)) begin
            s_axis_tdata[q]  <= tdata_t'(draw_bits(`UL_DATA_WIDTH));
            s_axis_tstrb[q]  <= tstrb_t'(draw_bits(`UL_DATA_WIDTH / 8));
            s_axis_tuser[q]  <= {8'(q), 24'(seq_num[q])};   // port in the top byte
            s_axis_tlast[q]  <= (beats_left[q] == 1);
            s_axis_tvalid[q] <= 1'b1;
            beats_left[q]    = beats_left[q] - 1;
         end else begin
            s_axis_tvalid[q] <= 1'b0;
         end
      end
   endtask

   // all sources and the sink, in one process so the LFSR order is fixed
   initial begin
      s_axis_tvalid = '0;
      s_axis_tlast  = '0;
      m_axis_tready = 1'b0;
      for (int q = 0; q < NQ; q++) begin
         s_axis_tdata[q] = '0;
         s_axis_tstrb[q] = '0;
         s_axis_tuser[q] = '0;
      end
      forever begin
         @(posedge axi_aclk);
         if (axi_resetn) begin
            for (int q = 0; q < NQ; q++) begin
               drive_port(q);
            end
            if (sink_rand) begin
               m_axis_tready <= (draw_bits(2) != '0);   // ready 3 cycles in 4
            end else begin
               m_axis_tready <= sink_level;
            end
         end
      end
   end

   function automatic beat_t ingress_beat(input int q);
      beat_t b;
      b.tlast = s_axis_tlast[q];
      b.tuser = s_axis_tuser[q];
      b.tstrb = s_axis_tstrb[q];
      b.tdata = s_axis_tdata[q];
      return b;
   endfunction

   task automatic check_output_beat();
      int    port;
      beat_t want;
      port = int'(m_axis_tuser[31:24]);
      if (port >= NQ) begin
         stop_with_failure($sformatf("output beat names port %0d, which does not exist", port));
      end else if (exp_q[port].size() == 0) begin
         stop_with_failure($sformatf("output beat for port %0d with none pending", port));
      end else begin
         want = exp_q[port].pop_front();
         if (in_pkt) begin
            check_user("m_axis_tuser inside packet", m_axis_tuser, pkt_user);   // no interleave
         end else begin
            pkt_user = m_axis_tuser;
            out_order.push_back(queue_idx_t'(port));
         end
         check_data("m_axis_tdata", m_axis_tdata, want.tdata);
         check_strb("m_axis_tstrb", m_axis_tstrb, want.tstrb);
         check_user("m_axis_tuser", m_axis_tuser, want.tuser);
         check_last("m_axis_tlast", m_axis_tlast, want.tlast);
         in_pkt  = !m_axis_tlast;
         out_cnt = out_cnt + 1;
      end
   endtask

   // model update on every handshake
   always @(posedge axi_aclk) begin
      if (axi_resetn) begin
         for (int q = 0; q < NQ; q++) begin
            if (s_axis_tvalid[q] && s_axis_tready[q]) begin
               exp_q[q].push_back(ingress_beat(q));
               acc_cnt[q] = acc_cnt[q] + 1;
            end
         end
         if (m_axis_tvalid && m_axis_tready) begin
            check_output_beat();
         end
      end
   end

   function automatic bit model_empty();
      bit e;
      e = 1'b1;
      for (int q = 0; q < NQ; q++) begin
         if (exp_q[q].size() != 0) e = 1'b0;
      end
      return e;
   endfunction

   function automatic bit sources_idle();
      bit idle;
      idle = (s_axis_tvalid == '0);
      for (int q = 0; q < NQ; q++) begin
         if (beats_left[q] != 0 || seq_num[q] < pkt_quota[q]) idle = 1'b0;
      end
      return idle;
   endfunction

   function automatic int total_accepted();
      int sum;
      sum = 0;
      for (int q = 0; q < NQ; q++) begin
         sum = sum + acc_cnt[q];
      end
      return sum;
   endfunction

   task automatic check_idle_outputs();
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      for (int q = 0; q < NQ; q++) begin
         check_flag($sformatf("s_axis_tready[%0d]", q), s_axis_tready[q], 1'b1);
      end
   endtask

   task automatic run_round_robin();
      sink_level   = 1'b0;
      pkt_quota[0] = 1;
      // only queue 0 has data, so valid means the pointer parked on it
      while (!m_axis_tvalid) begin
         @(negedge axi_aclk);
      end
      for (int q = 1; q < NQ; q++) begin
         pkt_quota[q] = 1;
      end
      while (!sources_idle()) begin
         @(negedge axi_aclk);
      end
      sink_level = 1'b1;
      while (!(model_empty() && out_order.size() == NQ)) begin
         @(negedge axi_aclk);
      end
      for (int i = 0; i < NQ; i++) begin
         check_port("output packet port", out_order[i], queue_idx_t'(i));
      end
   endtask

   task automatic run_ingress_backpressure();
      int base;
      int got;
      sink_level         = 1'b0;
      base               = acc_cnt[BP_PORT];
      pkt_quota[BP_PORT] = seq_num[BP_PORT] + 1000;   // valid stays up all window
      repeat (FIFO_FILL + 8) begin
         @(negedge axi_aclk);
         check_flag($sformatf("s_axis_tready[%0d]", BP_PORT), s_axis_tready[BP_PORT],
                    (acc_cnt[BP_PORT] - base) < FIFO_FILL);
      end
      got = acc_cnt[BP_PORT] - base;
      if (got != FIFO_FILL) begin
         stop_with_failure($sformatf("FAIL accepted beats on port %0d got 0x%h expected 0x%h",
                                     BP_PORT, got, FIFO_FILL));
      end
      pkt_quota[BP_PORT] = seq_num[BP_PORT];   // finish the open packet only
      sink_level         = 1'b1;
      while (!(sources_idle() && model_empty())) begin
         @(negedge axi_aclk);
      end
   endtask

   task automatic run_random_traffic();
      gap_en    = 1'b1;
      sink_rand = 1'b1;
      for (int q = 0; q < NQ; q++) begin
         pkt_quota[q] = seq_num[q] + RAND_PKTS;
      end
      while (!(sources_idle() && model_empty())) begin
         @(negedge axi_aclk);
      end
      repeat (4) @(negedge axi_aclk);   // room for a stray extra beat
   endtask

   initial begin
      axi_resetn = 1'b0;
      // two checks inside reset, one just after
      for (int i = 0; i < 3; i++) begin
         @(posedge axi_aclk);
         if (i == 2) begin
            axi_resetn <= 1'b1;
         end
         @(negedge axi_aclk);
         check_idle_outputs();
      end

      run_round_robin();
      run_ingress_backpressure();
      run_random_traffic();

      if (model_empty() && out_cnt == total_accepted()) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         stop_with_failure("beats were lost or left behind at the end of the run");
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge axi_aclk);
      stop_with_failure("timeout: traffic did not drain within the cycle budget");
   end

endmodule

//--- flist.f
+incdir+hdl
hdl/ualink_pkg.sv
hdl/stream_fifo.sv
hdl/queue_arbiter.sv
hdl/ualink_ingress_top.sv
tb/tb_ualink_ingress.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the ingress stage testbench with Verilator and run it
# the log is searched for the pass line to decide the outcome

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
   --top-module tb_ualink_ingress \
   -f flist.f \
   --Mdir obj_dir -o sim_tb \
   && ./obj_dir/sim_tb | tee sim.log \
   || { echo "build or simulation aborted"; exit 1; }

grep -q "RESULT: PASS" sim.log \
   && { echo "simulation passed"; exit 0; } \
   || { echo "simulation failed, see sim.log"; exit 1; }
